/* hdl/mipsIsaPkg.sv */
// instruction encodings, ALU operation codes, register file sizes and the instruction word union
package mipsIsaPkg;

    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of OP_SPECIAL
    localparam logic [5:0] FN_BREAK = 6'h0d;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI  // immediate into upper half
    } aluOp_e;

    // one instruction word seen as R, I or J format
    typedef union packed {
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0]            shamt;
            logic [5:0]            funct;
        } rType;
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm16;
        } iType;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target26;
        } jType;
    } instrWord_u;

endpackage

/* hdl/mipsMemPkg.sv */
// memory bus widths, reset vector and arbiter requester indices
package mipsMemPkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 32;  // byte address, low two bits zero

    localparam logic [ADDR_W-1:0] RESET_VECTOR = 32'h0000_0000;

    // requester indices at the arbiter
    localparam logic REQ_LSU   = 1'b0;
    localparam logic REQ_FETCH = 1'b1;

endpackage

/* hdl/memBusIf.sv */
// memory bus interface between one requester and the arbiter, with its modports
`timescale 1ns/10ps

interface memBusIf;

    logic                            req;     // held until gnt
    logic [mipsMemPkg::ADDR_W-1:0]   addr;
    logic                            wrEn;
    logic [mipsMemPkg::WORD_W-1:0]   wrData;
    logic                            gnt;
    logic [mipsMemPkg::WORD_W-1:0]   rdData;  // valid the cycle after gnt

    modport requester (
        output req, addr, wrEn, wrData,
        input  gnt, rdData
    );

    modport arbiter (
        input  req, addr, wrEn, wrData,
        output gnt, rdData
    );

endinterface

/* hdl/memArbiter.sv */
// memArbiter: fixed-priority arbiter sharing one memory bus between load/store and fetch
`timescale 1ns/10ps

module memArbiter (
    input  logic                          clk,
    input  logic                          reset_i,
    memBusIf.arbiter                      lsuBus_i,
    memBusIf.arbiter                      fetchBus_i,
    output logic                          memReq_o,
    output logic [mipsMemPkg::ADDR_W-1:0] memAddr_o,
    output logic                          memWrEn_o,
    output logic [mipsMemPkg::WORD_W-1:0] memWrData_o,
    input  logic [mipsMemPkg::WORD_W-1:0] memRdData_i
);

    logic sel;         // requester driving the bus this cycle
    logic owner;       // requester granted on the previous cycle
    logic ownerValid;

    // load/store always wins
    assign sel = lsuBus_i.req ? mipsMemPkg::REQ_LSU : mipsMemPkg::REQ_FETCH;

    assign memReq_o    = lsuBus_i.req | fetchBus_i.req;
    assign memAddr_o   = (sel == mipsMemPkg::REQ_LSU) ? lsuBus_i.addr : fetchBus_i.addr;
    assign memWrData_o = (sel == mipsMemPkg::REQ_LSU) ? lsuBus_i.wrData : fetchBus_i.wrData;
    assign memWrEn_o   = (sel == mipsMemPkg::REQ_LSU) ? lsuBus_i.wrEn : fetchBus_i.wrEn;

    assign lsuBus_i.gnt   = lsuBus_i.req;
    assign fetchBus_i.gnt = fetchBus_i.req & ~lsuBus_i.req;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            owner      <= mipsMemPkg::REQ_FETCH;
            ownerValid <= 1'b0;
        end else begin
            owner      <= sel;
            ownerValid <= memReq_o;
        end
    end

    // returning read data goes to its owner only
    assign lsuBus_i.rdData   = (ownerValid && owner == mipsMemPkg::REQ_LSU) ? memRdData_i : '0;
    assign fetchBus_i.rdData = (ownerValid && owner == mipsMemPkg::REQ_FETCH) ? memRdData_i : '0;

endmodule

/* hdl/fetchUnit.sv */
// fetchUnit: program counter, one-entry prefetch buffer and branch redirect
`timescale 1ns/10ps

module fetchUnit (
    input  logic                          clk,
    input  logic                          reset_i,
    memBusIf.requester                    bus_o,
    output logic                          instrValid_o,
    output mipsIsaPkg::instrWord_u        instr_o,
    output logic [mipsMemPkg::ADDR_W-1:0] pcPlus4_o,
    input  logic                          instrTake_i,
    input  logic                          redirect_i,
    input  logic [mipsMemPkg::ADDR_W-1:0] redirectPc_i
);

    logic [mipsMemPkg::ADDR_W-1:0] fetchPc;  // next address to request
    logic                          inFlight; // read data returns this cycle
    logic                          stale;    // returning word belongs to a dead path
    logic                          bufLoad;

    // one word in flight at a time, start once the buffer frees up
    assign bus_o.req    = !inFlight && (!instrValid_o || instrTake_i);
    assign bus_o.addr   = fetchPc;
    assign bus_o.wrEn   = 1'b0;
    assign bus_o.wrData = '0;

    assign bufLoad = inFlight && !stale && !redirect_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetchPc      <= mipsMemPkg::RESET_VECTOR;
            inFlight     <= 1'b0;
            stale        <= 1'b0;
            instrValid_o <= 1'b0;
        end else begin
            inFlight <= bus_o.gnt;
            stale    <= bus_o.gnt && redirect_i;  // granted on the old path
            if (redirect_i) begin
                fetchPc <= redirectPc_i;
            end else if (bus_o.gnt) begin
                fetchPc <= fetchPc + 32'd4;
            end
            if (bufLoad) begin
                instrValid_o <= 1'b1;
            end else if (instrTake_i) begin
                instrValid_o <= 1'b0;  // also covers redirect
            end
        end
    end

    // fetchPc already moved past the returning word
    always_ff @(posedge clk) begin
        if (bufLoad) begin
            instr_o   <= bus_o.rdData;
            pcPlus4_o <= fetchPc;
        end
    end

endmodule

/* hdl/loadStoreUnit.sv */
// loadStoreUnit: word loads and stores over the shared memory bus
`timescale 1ns/10ps

module loadStoreUnit (
    input  logic                          clk,
    input  logic                          reset_i,
    memBusIf.requester                    bus_o,
    input  logic                          lsStart_i,
    input  logic                          lsWrite_i,
    input  logic [mipsMemPkg::ADDR_W-1:0] lsAddr_i,
    input  logic [mipsMemPkg::WORD_W-1:0] lsData_i,
    output logic                          lsDone_o,
    output logic [mipsMemPkg::WORD_W-1:0] lsLoadData_o
);

    logic                          pending;    // request waiting for gnt
    logic                          storeDone;
    logic                          loadReturn; // read data on the bus now
    logic                          write;
    logic [mipsMemPkg::ADDR_W-1:0] addr;
    logic [mipsMemPkg::WORD_W-1:0] data;

    assign bus_o.req    = pending;
    assign bus_o.addr   = addr;
    assign bus_o.wrEn   = write;
    assign bus_o.wrData = data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending    <= 1'b0;
            storeDone  <= 1'b0;
            loadReturn <= 1'b0;
        end else begin
            storeDone  <= pending && bus_o.gnt && write;
            loadReturn <= pending && bus_o.gnt && !write;
            if (lsStart_i) begin
                pending <= 1'b1;
            end else if (bus_o.gnt) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lsStart_i) begin
            write <= lsWrite_i;
            addr  <= lsAddr_i;
            data  <= lsData_i;
        end
    end

    // both kinds finish one cycle after the grant
    assign lsDone_o     = storeDone | loadReturn;
    assign lsLoadData_o = bus_o.rdData;

endmodule

/* hdl/regFile.sv */
// regFile: 32 x 32 register file, two read ports, one write port, zero register
`timescale 1ns/10ps

module regFile (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [mipsIsaPkg::REG_ADDR_W-1:0] rdAddrA_i,
    input  logic [mipsIsaPkg::REG_ADDR_W-1:0] rdAddrB_i,
    output logic [mipsMemPkg::WORD_W-1:0]     rdDataA_o,
    output logic [mipsMemPkg::WORD_W-1:0]     rdDataB_o,
    input  logic                              wrEn_i,
    input  logic [mipsIsaPkg::REG_ADDR_W-1:0] wrAddr_i,
    input  logic [mipsMemPkg::WORD_W-1:0]     wrData_i
);

    logic [mipsMemPkg::WORD_W-1:0] regs [mipsIsaPkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < mipsIsaPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // r0 reads zero whatever was written
    assign rdDataA_o = (rdAddrA_i == '0) ? '0 : regs[rdAddrA_i];
    assign rdDataB_o = (rdAddrB_i == '0) ? '0 : regs[rdAddrB_i];

endmodule

/* hdl/execUnit.sv */
// execUnit: instruction decode, ALU, branch resolution and the memory-wait sequencer
`timescale 1ns/10ps

module execUnit (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              instrValid_i,
    input  mipsIsaPkg::instrWord_u            instr_i,
    input  logic [mipsMemPkg::ADDR_W-1:0]     pcPlus4_i,
    output logic                              instrTake_o,
    output logic                              redirect_o,
    output logic [mipsMemPkg::ADDR_W-1:0]     redirectPc_o,
    output logic [mipsIsaPkg::REG_ADDR_W-1:0] rdAddrA_o,
    output logic [mipsIsaPkg::REG_ADDR_W-1:0] rdAddrB_o,
    input  logic [mipsMemPkg::WORD_W-1:0]     rdDataA_i,
    input  logic [mipsMemPkg::WORD_W-1:0]     rdDataB_i,
    output logic                              wrEn_o,
    output logic [mipsIsaPkg::REG_ADDR_W-1:0] wrAddr_o,
    output logic [mipsMemPkg::WORD_W-1:0]     wrData_o,
    output logic                              lsStart_o,
    output logic                              lsWrite_o,
    output logic [mipsMemPkg::ADDR_W-1:0]     lsAddr_o,
    output logic [mipsMemPkg::WORD_W-1:0]     lsData_o,
    input  logic                              lsDone_i,
    input  logic [mipsMemPkg::WORD_W-1:0]     lsLoadData_i,
    output logic                              halted_o
);

    logic [mipsMemPkg::WORD_W-1:0]     immSext;
    logic [mipsMemPkg::WORD_W-1:0]     opB;
    logic [mipsMemPkg::WORD_W-1:0]     aluResult;
    mipsIsaPkg::aluOp_e                aluOp;
    logic                              aluWrEn;
    logic [mipsIsaPkg::REG_ADDR_W-1:0] aluDst;
    logic                              isLoad;
    logic                              isStore;
    logic                              isBreak;
    logic                              canTake;
    logic                              branchEq;
    logic                              memWait;     // sequencer: ready or waitMem
    logic                              loadPending;
    logic [mipsIsaPkg::REG_ADDR_W-1:0] loadDst;

    assign immSext = {{16{instr_i.iType.imm16[15]}}, instr_i.iType.imm16};
    assign isLoad  = instr_i.iType.op == mipsIsaPkg::OP_LW;
    assign isStore = instr_i.iType.op == mipsIsaPkg::OP_SW;
    assign isBreak = instr_i.rType.op == mipsIsaPkg::OP_SPECIAL &&
                     instr_i.rType.funct == mipsIsaPkg::FN_BREAK;

    assign canTake     = instrValid_i && !memWait && !halted_o;
    assign instrTake_o = canTake;
    assign rdAddrA_o   = instr_i.rType.rs;
    assign rdAddrB_o   = instr_i.rType.rt;

    // decode; loads and stores fall through as base plus offset
    always_comb begin
        aluOp   = mipsIsaPkg::ALU_ADD;
        opB     = immSext;
        aluWrEn = 1'b0;
        aluDst  = instr_i.iType.rt;
        case (instr_i.rType.op)
            mipsIsaPkg::OP_SPECIAL: begin
                opB     = rdDataB_i;
                aluDst  = instr_i.rType.rd;
                aluWrEn = 1'b1;
                case (instr_i.rType.funct)
                    mipsIsaPkg::FN_ADDU: aluOp = mipsIsaPkg::ALU_ADD;
                    mipsIsaPkg::FN_SUBU: aluOp = mipsIsaPkg::ALU_SUB;
                    mipsIsaPkg::FN_AND:  aluOp = mipsIsaPkg::ALU_AND;
                    mipsIsaPkg::FN_OR:   aluOp = mipsIsaPkg::ALU_OR;
                    mipsIsaPkg::FN_SLT:  aluOp = mipsIsaPkg::ALU_SLT;
                    default:             aluWrEn = 1'b0;  // BREAK writes nothing
                endcase
            end
            mipsIsaPkg::OP_ADDIU: aluWrEn = 1'b1;
            mipsIsaPkg::OP_LUI: begin
                aluOp   = mipsIsaPkg::ALU_LUI;
                aluWrEn = 1'b1;
            end
            default: aluWrEn = 1'b0;
        endcase
    end

    always_comb begin
        case (aluOp)
            mipsIsaPkg::ALU_SUB: aluResult = rdDataA_i - opB;
            mipsIsaPkg::ALU_AND: aluResult = rdDataA_i & opB;
            mipsIsaPkg::ALU_OR:  aluResult = rdDataA_i | opB;
            mipsIsaPkg::ALU_SLT: aluResult = {31'd0, $signed(rdDataA_i) < $signed(opB)};
            mipsIsaPkg::ALU_LUI: aluResult = {opB[15:0], 16'h0000};
            default:             aluResult = rdDataA_i + opB;
        endcase
    end

    // no delay slot, targets count from pc + 4
    assign branchEq = rdDataA_i == rdDataB_i;

    always_comb begin
        redirect_o   = 1'b0;
        redirectPc_o = pcPlus4_i + {immSext[29:0], 2'b00};
        case (instr_i.jType.op)
            mipsIsaPkg::OP_BEQ: redirect_o = canTake && branchEq;
            mipsIsaPkg::OP_BNE: redirect_o = canTake && !branchEq;
            mipsIsaPkg::OP_J: begin
                redirect_o   = canTake;
                redirectPc_o = {pcPlus4_i[31:28], instr_i.jType.target26, 2'b00};
            end
            default: redirect_o = 1'b0;
        endcase
    end

    assign lsStart_o = canTake && (isLoad || isStore);
    assign lsWrite_o = isStore;
    assign lsAddr_o  = aluResult;
    assign lsData_o  = rdDataB_i;

    // load data lands in the cycle of lsDone
    assign wrEn_o   = memWait ? (lsDone_i && loadPending) : (canTake && aluWrEn);
    assign wrAddr_o = memWait ? loadDst : aluDst;
    assign wrData_o = memWait ? lsLoadData_i : aluResult;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            memWait     <= 1'b0;
            loadPending <= 1'b0;
            halted_o    <= 1'b0;
        end else begin
            if (lsStart_o) begin
                memWait     <= 1'b1;
                loadPending <= isLoad;
            end else if (lsDone_i) begin
                memWait <= 1'b0;
            end
            if (canTake && isBreak) begin
                halted_o <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lsStart_o) begin
            loadDst <= instr_i.iType.rt;
        end
    end

endmodule

/* hdl/mipsCore.sv */
// mipsCore: top level joining fetch, execute, register file, load/store and memory arbiter
`timescale 1ns/10ps

module mipsCore (
    input  logic                          clk,
    input  logic                          reset_i,
    output logic                          memReq_o,
    output logic [mipsMemPkg::ADDR_W-1:0] memAddr_o,
    output logic                          memWrEn_o,
    output logic [mipsMemPkg::WORD_W-1:0] memWrData_o,
    input  logic [mipsMemPkg::WORD_W-1:0] memRdData_i,
    output logic                          halted_o
);

    logic                              instrValid;  // fetch to execute
    mipsIsaPkg::instrWord_u            instr;
    logic [mipsMemPkg::ADDR_W-1:0]     pcPlus4;
    logic                              instrTake;
    logic                              redirect;
    logic [mipsMemPkg::ADDR_W-1:0]     redirectPc;
    logic [mipsIsaPkg::REG_ADDR_W-1:0] rdAddrA;     // register file
    logic [mipsIsaPkg::REG_ADDR_W-1:0] rdAddrB;
    logic [mipsMemPkg::WORD_W-1:0]     rdDataA;
    logic [mipsMemPkg::WORD_W-1:0]     rdDataB;
    logic                              wrEn;
    logic [mipsIsaPkg::REG_ADDR_W-1:0] wrAddr;
    logic [mipsMemPkg::WORD_W-1:0]     wrData;
    logic                              lsStart;     // execute to load/store
    logic                              lsWrite;
    logic [mipsMemPkg::ADDR_W-1:0]     lsAddr;
    logic [mipsMemPkg::WORD_W-1:0]     lsData;
    logic                              lsDone;
    logic [mipsMemPkg::WORD_W-1:0]     lsLoadData;

    memBusIf fetchBus ();
    memBusIf lsuBus ();

    fetchUnit u_fetchUnit (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_o        (fetchBus.requester),
        .instrValid_o (instrValid),
        .instr_o      (instr),
        .pcPlus4_o    (pcPlus4),
        .instrTake_i  (instrTake),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc)
    );

    execUnit u_execUnit (
        .clk          (clk),
        .reset_i      (reset_i),
        .instrValid_i (instrValid),
        .instr_i      (instr),
        .pcPlus4_i    (pcPlus4),
        .instrTake_o  (instrTake),
        .redirect_o   (redirect),
        .redirectPc_o (redirectPc),
        .rdAddrA_o    (rdAddrA),
        .rdAddrB_o    (rdAddrB),
        .rdDataA_i    (rdDataA),
        .rdDataB_i    (rdDataB),
        .wrEn_o       (wrEn),
        .wrAddr_o     (wrAddr),
        .wrData_o     (wrData),
        .lsStart_o    (lsStart),
        .lsWrite_o    (lsWrite),
        .lsAddr_o     (lsAddr),
        .lsData_o     (lsData),
        .lsDone_i     (lsDone),
        .lsLoadData_i (lsLoadData),
        .halted_o     (halted_o)
    );

    regFile u_regFile (
        .clk       (clk),
        .reset_i   (reset_i),
        .rdAddrA_i (rdAddrA),
        .rdAddrB_i (rdAddrB),
        .rdDataA_o (rdDataA),
        .rdDataB_o (rdDataB),
        .wrEn_i    (wrEn),
        .wrAddr_i  (wrAddr),
        .wrData_i  (wrData)
    );

    loadStoreUnit u_loadStoreUnit (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_o        (lsuBus.requester),
        .lsStart_i    (lsStart),
        .lsWrite_i    (lsWrite),
        .lsAddr_i     (lsAddr),
        .lsData_i     (lsData),
        .lsDone_o     (lsDone),
        .lsLoadData_o (lsLoadData)
    );

    memArbiter u_memArbiter (
        .clk         (clk),
        .reset_i     (reset_i),
        .lsuBus_i    (lsuBus.arbiter),
        .fetchBus_i  (fetchBus.arbiter),
        .memReq_o    (memReq_o),
        .memAddr_o   (memAddr_o),
        .memWrEn_o   (memWrEn_o),
        .memWrData_o (memWrData_o),
        .memRdData_i (memRdData_i)
    );

endmodule

/* verification/memArbiter_properties.sv */
// concurrent assertions on memArbiter grants and write enable, with the bind into memArbiter
`timescale 1ns/10ps

module memArbiterProperties (
    input logic clk,
    input logic reset_i,
    input logic sel_i,
    input logic lsuReq_i,
    input logic lsuGnt_i,
    input logic fetchGnt_i,
    input logic memReq_i,
    input logic memWrEn_i
);

    oneGrant: assert property (@(posedge clk) disable iff (reset_i)
        !(lsuGnt_i && fetchGnt_i))
        else $error("both requesters granted in one cycle");

    // load/store has fixed priority
    lsuWins: assert property (@(posedge clk) disable iff (reset_i)
        lsuReq_i |-> (sel_i == mipsMemPkg::REQ_LSU) && lsuGnt_i && !fetchGnt_i)
        else $error("load/store request not granted first");

    writeNeedsReq: assert property (@(posedge clk) disable iff (reset_i)
        memWrEn_i |-> memReq_i)
        else $error("memWrEn_o high without memReq_o");

    noWriteAfterReset: assert property (@(posedge clk)
        $fell(reset_i) |-> !memWrEn_i)
        else $error("memWrEn_o high right after reset");

endmodule

bind memArbiter memArbiterProperties u_memArbiterProperties (
    .clk        (clk),
    .reset_i    (reset_i),
    .sel_i      (sel),
    .lsuReq_i   (lsuBus_i.req),
    .lsuGnt_i   (lsuBus_i.gnt),
    .fetchGnt_i (fetchBus_i.gnt),
    .memReq_i   (memReq_o),
    .memWrEn_i  (memWrEn_o)
);

/* verification/tbMipsCore.sv */
// testbench for mipsCore: clock, reset, memory model with store log, directed program tests
`timescale 1ns/10ps

module tbMipsCore;

    localparam int MEM_WORDS      = 256;
    localparam int MEM_BYTES      = MEM_WORDS * 4;
    localparam int TIMEOUT_CYCLES = 65 * 6 + 200;  // 65 instructions over all programs

    logic                          clk;
    logic                          reset_i;
    logic                          memReq;
    logic [mipsMemPkg::ADDR_W-1:0] memAddr;
    logic                          memWrEn;
    logic [mipsMemPkg::WORD_W-1:0] memWrData;
    logic [mipsMemPkg::WORD_W-1:0] memRdData;
    logic                          halted;

    logic [31:0] mem [MEM_WORDS];
    logic        rdPending;
    logic [7:0]  rdIdx;
    logic        wrPending;
    logic [31:0] wrAddr;
    logic [31:0] wrWord;
    logic [7:0]  progPtr;
    logic [31:0] logAddr [$];  // stores seen on the bus
    logic [31:0] logData [$];
    logic [31:0] expAddr [$];  // stores the ISA predicts
    logic [31:0] expData [$];
    int          errors = 0;
    int          cycleCount = 0;

    mipsCore u_mipsCore (
        .clk         (clk),
        .reset_i     (reset_i),
        .memReq_o    (memReq),
        .memAddr_o   (memAddr),
        .memWrEn_o   (memWrEn),
        .memWrData_o (memWrData),
        .memRdData_i (memRdData),
        .halted_o    (halted)
    );

    always #20 clk = ~clk;

    // request seen now is granted at the next edge, data follows one cycle later
    always @(negedge clk) begin
        memRdData = rdPending ? mem[rdIdx] : '0;
        rdPending = memReq && !memWrEn;
        rdIdx     = memAddr[9:2];
        wrPending = memReq && memWrEn;
        wrAddr    = memAddr;
        wrWord    = memWrData;
        if (memReq && memAddr >= MEM_BYTES) begin
            errors++;
            $display("access at %h lies outside the memory model", memAddr);
        end
    end

    always @(posedge clk) begin
        if (wrPending) begin  // write lands at the granted edge
            mem[wrAddr[9:2]] = wrWord;
            logAddr.push_back(wrAddr);
            logData.push_back(wrWord);
            wrPending = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] encR(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                         logic [4:0] rd);
        return {mipsIsaPkg::OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(logic [25:0] target);
        return {mipsIsaPkg::OP_J, target};
    endfunction

    function automatic logic [31:0] signExtend(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic emit(logic [31:0] word);
        mem[progPtr] = word;
        progPtr = progPtr + 8'd1;
    endtask

    // LUI then ADDIU, upper half rounded for the sign-extended low half
    task automatic loadConst(logic [4:0] rd, logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h0000_8000) >> 16;
        emit(encI(mipsIsaPkg::OP_LUI, 0, rd, hi[15:0]));
        emit(encI(mipsIsaPkg::OP_ADDIU, rd, rd, value[15:0]));
    endtask

    task automatic expectStore(logic [31:0] addr, logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic aluAndStore(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                               logic [4:0] rd, logic [15:0] addr);
        emit(encR(funct, rs, rt, rd));
        emit(encI(mipsIsaPkg::OP_SW, 0, rd, addr));
    endtask

    task automatic markerStore(logic [15:0] addr, logic onPath);
        emit(encI(mipsIsaPkg::OP_SW, 0, 1, addr));  // r1 holds 5
        if (onPath) begin
            expectStore({16'd0, addr}, 32'd5);
        end
    endtask

    task automatic holdReset();
        @(negedge clk);
        reset_i = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i[7:0]] = 32'hC0DE_0000 ^ (i << 2);
        end
        progPtr = '0;
        logAddr.delete();
        logData.delete();
        expAddr.delete();
        expData.delete();
    endtask

    task automatic releaseReset();
        repeat (2) @(negedge clk);
        reset_i = 1'b0;
    endtask

    task automatic runUntilHalt();
        int cap;
        int cycles;
        cap = progPtr * 6 + 20;
        cycles = 0;
        while (!halted && cycles < cap) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            errors++;
            $display("program did not reach BREAK within %0d cycles", cap);
        end
    endtask

    task automatic checkStores();
        int n;
        n = logAddr.size();
        if (n != expAddr.size()) begin
            errors++;
            $display("saw %0d stores where %0d were expected", n, expAddr.size());
            if (expAddr.size() < n) n = expAddr.size();
        end
        for (int i = 0; i < n; i++) begin
            checkValue("memAddr_o", logAddr[i], expAddr[i]);
            checkValue("memWrData_o", logData[i], expData[i]);
        end
    endtask

    task automatic testReset();
        holdReset();
        emit(encR(mipsIsaPkg::FN_BREAK, 0, 0, 0));
        releaseReset();
        checkValue("memReq_o", 32'(memReq), 32'd1);
        checkValue("memAddr_o", memAddr, mipsMemPkg::RESET_VECTOR);
        checkValue("memWrEn_o", 32'(memWrEn), 32'd0);
        checkValue("halted_o", 32'(halted), 32'd0);
        runUntilHalt();
        checkStores();
    endtask

    task automatic testAluOps();
        logic [31:0] a;
        logic [31:0] b;
        holdReset();
        a = $urandom;
        b = $urandom;
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        aluAndStore(mipsIsaPkg::FN_ADDU, 1, 2, 3, 16'h0300);
        expectStore(32'h300, a + b);
        aluAndStore(mipsIsaPkg::FN_SUBU, 1, 2, 4, 16'h0304);
        expectStore(32'h304, a - b);
        aluAndStore(mipsIsaPkg::FN_AND, 1, 2, 5, 16'h0308);
        expectStore(32'h308, a & b);
        aluAndStore(mipsIsaPkg::FN_OR, 1, 2, 6, 16'h030c);
        expectStore(32'h30c, a | b);
        aluAndStore(mipsIsaPkg::FN_SLT, 1, 2, 7, 16'h0310);
        expectStore(32'h310, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        aluAndStore(mipsIsaPkg::FN_SLT, 2, 1, 8, 16'h0314);
        expectStore(32'h314, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        aluAndStore(mipsIsaPkg::FN_ADDU, 1, 2, 0, 16'h0318);  // r0 must stay zero
        expectStore(32'h318, 32'd0);
        emit(encR(mipsIsaPkg::FN_BREAK, 0, 0, 0));
        releaseReset();
        runUntilHalt();
        checkStores();
    endtask

    task automatic testLoads();
        logic [31:0] w0;
        logic [31:0] w1;
        logic [15:0] i0;
        logic [15:0] i1;
        logic [15:0] i2;
        holdReset();
        w0 = $urandom;
        w1 = $urandom;
        i0 = 16'($urandom);
        i1 = 16'($urandom);
        i2 = 16'($urandom);
        mem[8'hd0] = w0;  // 0x340
        mem[8'hd1] = w1;  // 0x344
        emit(encI(mipsIsaPkg::OP_LW, 0, 1, 16'h0340));
        emit(encI(mipsIsaPkg::OP_ADDIU, 1, 2, i0));
        emit(encI(mipsIsaPkg::OP_SW, 0, 2, 16'h0380));
        expectStore(32'h380, w0 + signExtend(i0));
        emit(encI(mipsIsaPkg::OP_LW, 0, 3, 16'h0344));
        emit(encI(mipsIsaPkg::OP_ADDIU, 3, 4, i1));
        emit(encI(mipsIsaPkg::OP_SW, 0, 4, 16'h0384));
        expectStore(32'h384, w1 + signExtend(i1));
        emit(encI(mipsIsaPkg::OP_ADDIU, 0, 5, 16'h0340));  // base register plus offset
        emit(encI(mipsIsaPkg::OP_LW, 5, 6, 16'h0004));
        emit(encI(mipsIsaPkg::OP_ADDIU, 6, 7, i2));
        emit(encI(mipsIsaPkg::OP_SW, 0, 7, 16'h0388));
        expectStore(32'h388, w1 + signExtend(i2));
        emit(encR(mipsIsaPkg::FN_BREAK, 0, 0, 0));
        releaseReset();
        runUntilHalt();
        checkStores();
    endtask

    task automatic testBranches();
        holdReset();
        emit(encI(mipsIsaPkg::OP_ADDIU, 0, 1, 16'd5));
        emit(encI(mipsIsaPkg::OP_ADDIU, 0, 2, 16'd5));
        emit(encI(mipsIsaPkg::OP_ADDIU, 0, 3, 16'd7));
        markerStore(16'h03a0, 1'b1);
        emit(encI(mipsIsaPkg::OP_BEQ, 1, 2, 16'd1));  // taken
        markerStore(16'h03a4, 1'b0);
        markerStore(16'h03a8, 1'b1);
        emit(encI(mipsIsaPkg::OP_BEQ, 1, 3, 16'd1));  // falls through
        markerStore(16'h03ac, 1'b1);
        emit(encI(mipsIsaPkg::OP_BNE, 1, 3, 16'd1));  // taken
        markerStore(16'h03b0, 1'b0);
        markerStore(16'h03b4, 1'b1);
        emit(encI(mipsIsaPkg::OP_BNE, 1, 2, 16'd1));  // falls through
        markerStore(16'h03b8, 1'b1);
        emit(encJ(26'd16));                           // word 14 jumps to word 16
        markerStore(16'h03bc, 1'b0);
        markerStore(16'h03c0, 1'b1);
        emit(encR(mipsIsaPkg::FN_BREAK, 0, 0, 0));
        releaseReset();
        runUntilHalt();
        checkStores();
    endtask

    task automatic testBusContention();
        logic [31:0] v1;
        logic [31:0] v2;
        holdReset();
        v1 = $urandom;
        v2 = $urandom;
        loadConst(5'd1, v1);
        loadConst(5'd2, v2);
        emit(encI(mipsIsaPkg::OP_SW, 0, 1, 16'h03d0));  // back-to-back stores
        emit(encI(mipsIsaPkg::OP_SW, 0, 2, 16'h03d4));
        emit(encI(mipsIsaPkg::OP_LW, 0, 3, 16'h03d0));
        emit(encI(mipsIsaPkg::OP_SW, 0, 3, 16'h03d8));
        emit(encI(mipsIsaPkg::OP_LW, 0, 4, 16'h03d4));
        emit(encR(mipsIsaPkg::FN_ADDU, 3, 4, 5));
        emit(encI(mipsIsaPkg::OP_SW, 0, 5, 16'h03dc));
        emit(encI(mipsIsaPkg::OP_LW, 0, 6, 16'h03dc));  // reads the word just stored
        emit(encI(mipsIsaPkg::OP_SW, 0, 6, 16'h03e0));
        emit(encI(mipsIsaPkg::OP_ADDIU, 0, 7, 16'h03e0));
        emit(encI(mipsIsaPkg::OP_SW, 7, 4, 16'h0004));
        emit(encR(mipsIsaPkg::FN_BREAK, 0, 0, 0));
        expectStore(32'h3d0, v1);
        expectStore(32'h3d4, v2);
        expectStore(32'h3d8, v1);
        expectStore(32'h3dc, v1 + v2);
        expectStore(32'h3e0, v1 + v2);
        expectStore(32'h3e4, v2);
        releaseReset();
        runUntilHalt();
        repeat (8) begin
            @(negedge clk);
            if (!halted) begin
                errors++;
                $display("halted_o dropped after BREAK at %0t", $time);
            end
        end
        checkStores();
        for (int i = 0; i < expAddr.size(); i++) begin
            checkValue("mem", mem[expAddr[i][9:2]], expData[i]);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset_i   = 1'b1;
        memRdData = '0;
        rdPending = 1'b0;
        wrPending = 1'b0;
        progPtr   = '0;
        void'($urandom(32'h8920));
        testReset();
        testAluOps();
        testLoads();
        testBranches();
        testBusContention();
        $display("tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/mipsIsaPkg.sv
hdl/mipsMemPkg.sv
hdl/memBusIf.sv
hdl/memArbiter.sv
hdl/fetchUnit.sv
hdl/loadStoreUnit.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/mipsCore.sv
verification/memArbiter_properties.sv
verification/tbMipsCore.sv

/* Makefile */
# Verilator build and run of the mipsCore testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -f compile.f --top-module tbMipsCore \
		-Mdir obj_dir -o simMipsCore
	./obj_dir/simMipsCore > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
